// File: files.f
+incdir+common
common/taiga_lite_pkg.sv
fetch/instruction_fetch.sv
decode/decode_issue.sv
logic/register_file.sv
logic/alu_unit.sv
logic/taiga_lite_core.sv
tests/tb_taiga_lite_core.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f files.f --top-module tb_taiga_lite_core -o tb_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_sim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation completed successfully$"; then
    exit 0
fi
exit 1

// File: tests/tb_taiga_lite_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "taiga_lite_consts.svh"

module tb_taiga_lite_core;

    localparam int CLK_PERIOD = 100;
    localparam int DRIVE_DELAY = 1;
    localparam int NUM_TESTS = 5;

    logic clk;
    logic rst;
    taiga_lite_pkg::addr_t instr_addr;
    logic instr_req;
    taiga_lite_pkg::instr_t instr_data;
    logic retire_valid;
    taiga_lite_pkg::reg_addr_t retire_rd;
    taiga_lite_pkg::word_t retire_data;

    // Program image and the test that owns each word
    taiga_lite_pkg::instr_t imem [256];
    int prog_test [256];
    int prog_len;
    bit build_done;

    // Reference model state and expected retire events
    taiga_lite_pkg::word_t model_regs [`NUM_REGS];
    taiga_lite_pkg::reg_addr_t exp_rd [$];
    taiga_lite_pkg::word_t exp_data [$];
    int exp_test [$];

    int test_expected [NUM_TESTS];
    int test_checked [NUM_TESTS];
    int test_errors [NUM_TESTS];
    bit test_done [NUM_TESTS];
    int tests_passed;
    int tests_failed;
    int check_count;
    int error_count;
    int retire_count;
    int extra_count;
    int expected_total;

    // Memory model request capture
    logic pend_req;
    taiga_lite_pkg::addr_t pend_addr;

    taiga_lite_core UUT (
        .clk (clk),
        .rst (rst),
        .instr_addr (instr_addr),
        .instr_req (instr_req),
        .instr_data (instr_data),
        .retire_valid (retire_valid),
        .retire_rd (retire_rd),
        .retire_data (retire_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //////////////////////////////
    // Program generation
    //////////////////////////////

    function automatic taiga_lite_pkg::reg_addr_t rand_reg();
        return 5'($urandom % 31) + 5'd1;
    endfunction

    // k selects ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    function automatic taiga_lite_pkg::instr_t make_op(input bit use_imm, input int k,
                                                       input taiga_lite_pkg::reg_addr_t rd,
                                                       input taiga_lite_pkg::reg_addr_t rs1,
                                                       input taiga_lite_pkg::reg_addr_t rs2,
                                                       input logic [11:0] imm);
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm_field;
        case (k)
            0, 1: f3 = `FUNCT3_ADD_SUB;
            2: f3 = `FUNCT3_SLL;
            3: f3 = `FUNCT3_SLT;
            4: f3 = `FUNCT3_SLTU;
            5: f3 = `FUNCT3_XOR;
            6, 7: f3 = `FUNCT3_SRL_SRA;
            8: f3 = `FUNCT3_OR;
            default: f3 = `FUNCT3_AND;
        endcase
        f7 = (k == 1 || k == 7) ? 7'b0100000 : 7'b0000000;
        if (!use_imm) begin
            return {f7, rs2, rs1, f3, rd, `OPCODE_OP};
        end
        imm_field = imm;
        // Shift immediates carry only a shift amount
        if (f3 == `FUNCT3_SLL || f3 == `FUNCT3_SRL_SRA) begin
            imm_field = {f7, imm[4:0]};
        end
        return {imm_field, rs1, f3, rd, `OPCODE_OP_IMM};
    endfunction

    function automatic void emit(input taiga_lite_pkg::instr_t ins, input int t);
        imem[prog_len] = ins;
        prog_test[prog_len] = t;
        prog_len++;
    endfunction

    task automatic build_program();
        taiga_lite_pkg::reg_addr_t rd;
        taiga_lite_pkg::reg_addr_t prev;
        logic [11:0] imm;
        for (int i = 0; i < 256; i++) begin
            imem[i] = `NOP_INSTR;
        end
        prog_len = 0;
        for (int r = 1; r < 17; r++) begin
            emit({20'($urandom), 5'(r), `OPCODE_LUI}, 0);
        end
        // Every other immediate is negative
        for (int i = 0; i < 40; i++) begin
            imm = 12'($urandom);
            if (i % 2 == 0) begin
                imm[11] = 1'b1;
            end
            emit(make_op(1'b1, i % 10, rand_reg(), rand_reg(), 5'd0, imm), 1);
        end
        for (int i = 0; i < 60; i++) begin
            emit(make_op(1'b0, i % 10, rand_reg(), rand_reg(), rand_reg(), 12'd0), 2);
        end
        // Each instruction reads the rd of the one before
        prev = rand_reg();
        for (int i = 0; i < 30; i++) begin
            rd = rand_reg();
            emit(make_op(i % 3 == 0, int'($urandom % 10), rd, prev,
                         (i % 2 == 0) ? prev : rand_reg(), 12'($urandom)), 3);
            prev = rd;
        end
        // Write x0, then read it back
        for (int i = 0; i < 10; i++) begin
            emit(make_op(i % 2 == 1, i, 5'd0, rand_reg(), rand_reg(), 12'($urandom)), 4);
            emit(make_op(1'b0, 0, rand_reg(), 5'd0, (i % 2 == 0) ? 5'd0 : rand_reg(), 12'd0), 4);
        end
    endtask

    //////////////////////////////
    // Reference model
    //////////////////////////////

    function automatic void execute_ref(input taiga_lite_pkg::instr_t ins, input int t);
        taiga_lite_pkg::reg_addr_t rd;
        taiga_lite_pkg::word_t a;
        taiga_lite_pkg::word_t b;
        taiga_lite_pkg::word_t v;
        logic [4:0] sh;
        bit writes;
        rd = ins[11:7];
        a = model_regs[ins[19:15]];
        b = (ins[6:0] == `OPCODE_OP) ? model_regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
        sh = b[4:0];
        writes = 1'b1;
        v = '0;
        case (ins[6:0])
            `OPCODE_LUI: v = {ins[31:12], 12'h000};
            `OPCODE_OP, `OPCODE_OP_IMM: begin
                case (ins[14:12])
                    `FUNCT3_ADD_SUB: v = (ins[6:0] == `OPCODE_OP && ins[30]) ? a - b : a + b;
                    `FUNCT3_SLL: v = a << sh;
                    `FUNCT3_SLT: v = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    `FUNCT3_SLTU: v = (a < b) ? 32'd1 : 32'd0;
                    `FUNCT3_XOR: v = a ^ b;
                    `FUNCT3_SRL_SRA: begin
                        v = a >> sh;
                        // Arithmetic form refills the top with the sign bit
                        if (ins[30] && a[31]) begin
                            v = v | ~(32'hffff_ffff >> sh);
                        end
                    end
                    `FUNCT3_OR: v = a | b;
                    default: v = a & b;
                endcase
            end
            default: writes = 1'b0;
        endcase
        if (writes && rd != 5'd0) begin
            model_regs[rd] = v;
            exp_rd.push_back(rd);
            exp_data.push_back(v);
            exp_test.push_back(t);
            test_expected[t]++;
        end
    endfunction

    function automatic void run_reference();
        for (int i = 0; i < `NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < prog_len; i++) begin
            execute_ref(imem[i], prog_test[i]);
        end
        expected_total = exp_rd.size();
    endfunction

    //////////////////////////////
    // Checks and reporting
    //////////////////////////////

    task automatic check_reg_addr(input int t, input string name,
                                  input taiga_lite_pkg::reg_addr_t got,
                                  input taiga_lite_pkg::reg_addr_t exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%02h, expected 0x%02h", name, got, exp);
            error_count++;
            test_errors[t]++;
        end
    endtask

    task automatic check_word(input int t, input string name,
                              input taiga_lite_pkg::word_t got,
                              input taiga_lite_pkg::word_t exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
            error_count++;
            test_errors[t]++;
        end
    endtask

    function automatic string test_name(input int t);
        case (t)
            0: return "LUI";
            1: return "immediate ALU forms";
            2: return "register-register ALU forms";
            3: return "dependent chain through bypass";
            default: return "x0 writes and reads";
        endcase
    endfunction

    task automatic report_test(input int t);
        bit ok;
        ok = (test_errors[t] == 0) && (test_checked[t] == test_expected[t]);
        $display("Test %0d (%s): %0d of %0d events checked, %0d errors, %s", t + 1,
                 test_name(t), test_checked[t], test_expected[t], test_errors[t],
                 ok ? "PASS" : "FAIL");
        if (ok) tests_passed++;
        else tests_failed++;
        test_done[t] = 1'b1;
    endtask

    task automatic handle_retire();
        int t;
        retire_count++;
        if (exp_rd.size() == 0) begin
            $display("Extra retire event: x%0d written with 0x%08h, none was expected",
                     retire_rd, retire_data);
            error_count++;
            extra_count++;
        end else begin
            t = exp_test.pop_front();
            check_reg_addr(t, "retire_rd", retire_rd, exp_rd.pop_front());
            check_word(t, "retire_data", retire_data, exp_data.pop_front());
            test_checked[t]++;
            if (test_checked[t] == test_expected[t]) report_test(t);
        end
    endtask

    task automatic finish_report();
        bit ok;
        taiga_lite_pkg::reg_addr_t m_rd;
        taiga_lite_pkg::word_t m_data;
        for (int t = 0; t < NUM_TESTS; t++) begin
            if (!test_done[t]) report_test(t);
        end
        ok = (retire_count == expected_total) && (exp_rd.size() == 0) && (extra_count == 0);
        while (exp_rd.size() > 0) begin
            m_rd = exp_rd.pop_front();
            m_data = exp_data.pop_front();
            void'(exp_test.pop_front());
            $display("Missing retire event: x%0d should have been written with 0x%08h",
                     m_rd, m_data);
        end
        $display("Test 6 (retire count): %0d retired, %0d expected, %0d extra, %s",
                 retire_count, expected_total, extra_count, ok ? "PASS" : "FAIL");
        if (ok) tests_passed++;
        else tests_failed++;
        $display("Summary: %0d tests passed, %0d failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, error_count);
    endtask

    //////////////////////////////
    // Processes
    //////////////////////////////

    // Instruction memory answers one cycle after each request
    initial begin
        forever begin
            @(negedge clk);
            pend_req = instr_req;
            pend_addr = instr_addr;
            @(posedge clk);
            #(DRIVE_DELAY);
            if (pend_req) begin
                instr_data = (pend_addr < 32'(4 * prog_len)) ? imem[pend_addr[9:2]] : `NOP_INSTR;
            end
        end
    end

    initial begin
        forever begin
            @(negedge clk);
            if (!rst && retire_valid) handle_retire();
        end
    end

    initial begin
        wait (build_done);
        #((prog_len + 20) * CLK_PERIOD);
        $display("Timeout: the program did not drain within %0d cycles", prog_len + 20);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        instr_data = `NOP_INSTR;
        build_done = 1'b0;
        void'($urandom(32'h1f68));
        build_program();
        run_reference();
        build_done = 1'b1;
        repeat (8) @(posedge clk);
        #(DRIVE_DELAY);
        rst = 1'b0;
        // Wait until fetch runs well past the end of the program
        while (instr_addr < 32'(4 * (prog_len + 6))) begin
            @(negedge clk);
        end
        // Retire sampling at the falling edge has settled by now
        @(posedge clk);
        finish_report();
        if (tests_failed == 0 && error_count == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: logic/taiga_lite_core.sv
`timescale 1ns/1ps
`default_nettype none

module taiga_lite_core (
    input  wire                         clk,
    input  wire                         rst,
    output taiga_lite_pkg::addr_t       instr_addr,
    output logic                        instr_req,
    input  wire taiga_lite_pkg::instr_t instr_data,
    output logic                        retire_valid,
    output taiga_lite_pkg::reg_addr_t   retire_rd,
    output taiga_lite_pkg::word_t       retire_data
);

    // Fetch to decode
    logic fetch_valid;
    taiga_lite_pkg::instr_t fetch_instr;

    // Register file reads
    taiga_lite_pkg::reg_addr_t rs1_addr;
    taiga_lite_pkg::reg_addr_t rs2_addr;
    taiga_lite_pkg::word_t rs1_data;
    taiga_lite_pkg::word_t rs2_data;

    // Issue packet
    logic issue_valid;
    taiga_lite_pkg::alu_op_t issue_op;
    taiga_lite_pkg::word_t issue_a;
    taiga_lite_pkg::word_t issue_b;
    taiga_lite_pkg::reg_addr_t issue_rd;

    //////////////////////////////
    // Fetch and decode
    //////////////////////////////

    instruction_fetch fetch_block (
        .clk (clk),
        .rst (rst),
        .instr_addr (instr_addr),
        .instr_req (instr_req),
        .instr_data (instr_data),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr)
    );

    decode_issue decode_issue_block (
        .clk (clk),
        .rst (rst),
        .fetch_valid (fetch_valid),
        .fetch_instr (fetch_instr),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .issue_valid (issue_valid),
        .issue_op (issue_op),
        .issue_a (issue_a),
        .issue_b (issue_b),
        .issue_rd (issue_rd)
    );

    //////////////////////////////
    // Execute and writeback
    //////////////////////////////

    // Writeback doubles as the retire trace port
    register_file register_file_block (
        .clk (clk),
        .rst (rst),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb_valid (retire_valid),
        .wb_rd (retire_rd),
        .wb_data (retire_data)
    );

    alu_unit alu_unit_block (
        .clk (clk),
        .rst (rst),
        .issue_valid (issue_valid),
        .issue_op (issue_op),
        .issue_a (issue_a),
        .issue_b (issue_b),
        .issue_rd (issue_rd),
        .wb_valid (retire_valid),
        .wb_rd (retire_rd),
        .wb_data (retire_data)
    );

endmodule

`default_nettype wire

// File: logic/alu_unit.sv
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
    input  wire                            clk,
    input  wire                            rst,
    input  wire                            issue_valid,
    input  wire taiga_lite_pkg::alu_op_t   issue_op,
    input  wire taiga_lite_pkg::word_t     issue_a,
    input  wire taiga_lite_pkg::word_t     issue_b,
    input  wire taiga_lite_pkg::reg_addr_t issue_rd,
    output logic                           wb_valid,
    output taiga_lite_pkg::reg_addr_t      wb_rd,
    output taiga_lite_pkg::word_t          wb_data
);

    logic [4:0] shamt;
    taiga_lite_pkg::word_t result;

    assign shamt = issue_b[4:0];

    //////////////////////////////
    // Operations
    //////////////////////////////

    always_comb begin
        case (issue_op)
            taiga_lite_pkg::ADD: result = issue_a + issue_b;
            taiga_lite_pkg::SUB: result = issue_a - issue_b;
            taiga_lite_pkg::SLL: result = issue_a << shamt;
            taiga_lite_pkg::SLT: result = {31'b0, $signed(issue_a) < $signed(issue_b)};
            taiga_lite_pkg::SLTU: result = {31'b0, issue_a < issue_b};
            taiga_lite_pkg::XOR: result = issue_a ^ issue_b;
            taiga_lite_pkg::SRL: result = issue_a >> shamt;
            taiga_lite_pkg::SRA: result = $unsigned($signed(issue_a) >>> shamt);
            taiga_lite_pkg::OR: result = issue_a | issue_b;
            taiga_lite_pkg::AND: result = issue_a & issue_b;
            // LUI immediate arrives already shifted
            taiga_lite_pkg::PASS_B: result = issue_b;
            default: result = '0;
        endcase
    end

    //////////////////////////////
    // Writeback register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        wb_rd <= issue_rd;
        wb_data <= result;
    end

endmodule

`default_nettype wire

// File: logic/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "taiga_lite_consts.svh"

module register_file (
    input  wire                            clk,
    input  wire                            rst,
    input  wire taiga_lite_pkg::reg_addr_t rs1_addr,
    input  wire taiga_lite_pkg::reg_addr_t rs2_addr,
    output taiga_lite_pkg::word_t          rs1_data,
    output taiga_lite_pkg::word_t          rs2_data,
    input  wire                            wb_valid,
    input  wire taiga_lite_pkg::reg_addr_t wb_rd,
    input  wire taiga_lite_pkg::word_t     wb_data
);

    taiga_lite_pkg::word_t regs [`NUM_REGS];

    // x0 is never written, so it stays at its reset value of zero
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_valid && (wb_rd != 5'd0)) begin
            regs[wb_rd] <= wb_data;
        end
    end

    //////////////////////////////
    // Read ports with bypass
    //////////////////////////////

    function automatic taiga_lite_pkg::word_t read_port(input taiga_lite_pkg::reg_addr_t addr);
        if ((addr != 5'd0) && wb_valid && (wb_rd == addr)) begin
            read_port = wb_data;
        end else begin
            read_port = regs[addr];
        end
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
    end

    always_comb begin
        rs2_data = read_port(rs2_addr);
    end

endmodule

`default_nettype wire

// File: decode/decode_issue.sv
`timescale 1ns/1ps
`default_nettype none

`include "taiga_lite_consts.svh"

module decode_issue (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         fetch_valid,
    input  wire taiga_lite_pkg::instr_t fetch_instr,
    output taiga_lite_pkg::reg_addr_t   rs1_addr,
    output taiga_lite_pkg::reg_addr_t   rs2_addr,
    input  wire taiga_lite_pkg::word_t  rs1_data,
    input  wire taiga_lite_pkg::word_t  rs2_data,
    output logic                        issue_valid,
    output taiga_lite_pkg::alu_op_t     issue_op,
    output taiga_lite_pkg::word_t       issue_a,
    output taiga_lite_pkg::word_t       issue_b,
    output taiga_lite_pkg::reg_addr_t   issue_rd
);

    // Instruction fields
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    taiga_lite_pkg::reg_addr_t rd;
    taiga_lite_pkg::reg_addr_t rs1;
    taiga_lite_pkg::reg_addr_t rs2;
    taiga_lite_pkg::word_t imm_i;
    taiga_lite_pkg::word_t imm_u;

    // Decoded packet before the stage register
    logic supported;
    logic use_imm;
    logic alt_op;
    taiga_lite_pkg::alu_op_t op;
    taiga_lite_pkg::word_t imm;

    // Issue stage register
    logic use_imm_q;
    taiga_lite_pkg::word_t imm_q;

    //////////////////////////////
    // Field extraction
    //////////////////////////////

    assign opcode = fetch_instr[6:0];
    assign rd = fetch_instr[11:7];
    assign funct3 = fetch_instr[14:12];
    assign rs1 = fetch_instr[19:15];
    assign rs2 = fetch_instr[24:20];
    assign funct7 = fetch_instr[31:25];

    assign imm_i = {{20{fetch_instr[31]}}, fetch_instr[31:20]};
    assign imm_u = {fetch_instr[31:12], 12'b0};

    // Bit 30 picks SUB over ADD (register form only) and SRA over SRL
    assign alt_op = funct7[5] &&
        ((opcode == `OPCODE_OP) || (funct3 == `FUNCT3_SRL_SRA));

    function automatic taiga_lite_pkg::alu_op_t funct3_to_op(input logic [2:0] f3,
                                                            input logic alt);
        case (f3)
            `FUNCT3_ADD_SUB: funct3_to_op = alt ? taiga_lite_pkg::SUB : taiga_lite_pkg::ADD;
            `FUNCT3_SLL: funct3_to_op = taiga_lite_pkg::SLL;
            `FUNCT3_SLT: funct3_to_op = taiga_lite_pkg::SLT;
            `FUNCT3_SLTU: funct3_to_op = taiga_lite_pkg::SLTU;
            `FUNCT3_XOR: funct3_to_op = taiga_lite_pkg::XOR;
            `FUNCT3_SRL_SRA: funct3_to_op = alt ? taiga_lite_pkg::SRA : taiga_lite_pkg::SRL;
            `FUNCT3_OR: funct3_to_op = taiga_lite_pkg::OR;
            default: funct3_to_op = taiga_lite_pkg::AND;
        endcase
    endfunction

    //////////////////////////////
    // Operation select
    //////////////////////////////

    always_comb begin
        op = funct3_to_op(funct3, alt_op);
        imm = imm_i;
        use_imm = 1'b1;
        supported = 1'b0;
        case (opcode)
            `OPCODE_OP: begin
                use_imm = 1'b0;
                // M extension encodings fall through as a bubble
                supported = (funct7 == 7'b0000000) ||
                    ((funct7 == 7'b0100000) &&
                     ((funct3 == `FUNCT3_ADD_SUB) || (funct3 == `FUNCT3_SRL_SRA)));
            end
            `OPCODE_OP_IMM: begin
                supported = 1'b1;
            end
            `OPCODE_LUI: begin
                op = taiga_lite_pkg::PASS_B;
                imm = imm_u;
                supported = 1'b1;
            end
            default: begin
                supported = 1'b0;
            end
        endcase
    end

    //////////////////////////////
    // Issue stage register
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            issue_valid <= 1'b0;
        end else begin
            // x0 targets and unknown opcodes never reach writeback
            issue_valid <= fetch_valid && supported && (rd != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        issue_op <= op;
        issue_rd <= rd;
        rs1_addr <= rs1;
        rs2_addr <= rs2;
        imm_q <= imm;
        use_imm_q <= use_imm;
    end

    // Operands read in the issue cycle so the writeback bypass covers
    // the instruction directly ahead
    assign issue_a = rs1_data;
    assign issue_b = use_imm_q ? imm_q : rs2_data;

endmodule

`default_nettype wire

// File: fetch/instruction_fetch.sv
`timescale 1ns/1ps
`default_nettype none

`include "taiga_lite_consts.svh"

module instruction_fetch (
    input  wire                     clk,
    input  wire                     rst,
    output taiga_lite_pkg::addr_t   instr_addr,
    output logic                    instr_req,
    input  wire taiga_lite_pkg::instr_t instr_data,
    output logic                    fetch_valid,
    output taiga_lite_pkg::instr_t  fetch_instr
);

    taiga_lite_pkg::addr_t pc;

    //////////////////////////////
    // PC and request
    //////////////////////////////

    // No branches, so the PC only steps forward by one word
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `RESET_PC;
            instr_req <= 1'b0;
        end else begin
            instr_req <= 1'b1;
            if (instr_req) begin
                pc <= pc + 32'd4;
            end
        end
    end

    assign instr_addr = pc;

    //////////////////////////////
    // Response
    //////////////////////////////

    // Memory answers exactly one cycle after a request
    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= instr_req;
        end
    end

    // Empty slots turn into a harmless NOP for decode
    assign fetch_instr = fetch_valid ? instr_data : `NOP_INSTR;

endmodule

`default_nettype wire

// File: common/taiga_lite_pkg.sv
`default_nettype none

package taiga_lite_pkg;

    //////////////////////////////
    // Datapath widths
    //////////////////////////////

    // General purpose data word
    typedef logic [31:0] word_t;

    // Byte address, used for the PC
    typedef logic [31:0] addr_t;

    // Raw RV32I instruction
    typedef logic [31:0] instr_t;

    // Architectural register index
    typedef logic [4:0] reg_addr_t;

    //////////////////////////////
    // ALU operations
    //////////////////////////////

    // PASS_B forwards the second operand, used by LUI
    typedef enum logic [3:0] {
        ADD    = 4'd0,
        SUB    = 4'd1,
        SLL    = 4'd2,
        SLT    = 4'd3,
        SLTU   = 4'd4,
        XOR    = 4'd5,
        SRL    = 4'd6,
        SRA    = 4'd7,
        OR     = 4'd8,
        AND    = 4'd9,
        PASS_B = 4'd10
    } alu_op_t;

endpackage

`default_nettype wire

// File: common/taiga_lite_consts.svh
`ifndef TAIGA_LITE_CONSTS_SVH
`define TAIGA_LITE_CONSTS_SVH

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Kept major opcodes
`define OPCODE_OP     7'b0110011
`define OPCODE_OP_IMM 7'b0010011
`define OPCODE_LUI    7'b0110111

// funct3 codes of the integer ALU group
`define FUNCT3_ADD_SUB 3'b000
`define FUNCT3_SLL     3'b001
`define FUNCT3_SLT     3'b010
`define FUNCT3_SLTU    3'b011
`define FUNCT3_XOR     3'b100
`define FUNCT3_SRL_SRA 3'b101
`define FUNCT3_OR      3'b110
`define FUNCT3_AND     3'b111

// ADDI x0, x0, 0
`define NOP_INSTR 32'h0000_0013

`define NUM_REGS 32

`endif
